//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module tb_tlb

out=$(./obj_dir/Vtb_tlb || true)
echo "$out"
if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
else
  exit 1
fi

//--- source/mips_mmu_pkg.sv
`default_nettype none

package mips_mmu_pkg;

  // Address bits 31..29 of the kernel segments
  localparam logic [2:0] SEG_KSEG0 = 3'b100;
  localparam logic [2:0] SEG_KSEG1 = 3'b101;
  localparam logic [2:0] SEG_KSEG2 = 3'b110;
  localparam logic [2:0] SEG_KSEG3 = 3'b111;

  localparam logic [tlb_cfg_pkg::CATTR_W-1:0] CACHE_CACHEABLE = 3'd3;

  // EntryHi layout
  localparam int HI_VPN2_LSB = 13;
  localparam int HI_ODD_BIT  = 12; // Only looked at by probe

  // EntryLo layout
  localparam int LO_PFN_LSB = 6;
  localparam int LO_C_LSB   = 3;
  localparam int LO_D_BIT   = 2;
  localparam int LO_V_BIT   = 1;
  localparam int LO_G_BIT   = 0;

  localparam logic [31:0] PROBE_MISS = 32'h8000_0000;

  typedef struct packed {
    logic [2:0]  seg;
    logic [28:0] rest;
  } vaddr_seg_t;

  typedef struct packed {
    logic [tlb_cfg_pkg::VPN2_W-1:0] vpn2;
    logic                           odd;
    logic [11:0]                    offset;
  } vaddr_page_t;

  // Same word seen as segment or as page
  typedef union packed {
    vaddr_seg_t  seg;
    vaddr_page_t page;
  } vaddr_u;

endpackage

`default_nettype wire

//--- source/tlb_cfg_pkg.sv
`default_nettype none

package tlb_cfg_pkg;

  // Entry count when the top level is not overridden
  localparam int TLB_ENTRIES_DEFAULT = 16;

  localparam int VPN2_W  = 19; // Even/odd page pair number
  localparam int ASID_W  = 8;
  localparam int PFN_W   = 20; // Doubles as the cache tag width
  localparam int CATTR_W = 3;

endpackage

`default_nettype wire

//--- source/tlb_data_port.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_data_port #(
  parameter  int TLB_ENTRIES = tlb_cfg_pkg::TLB_ENTRIES_DEFAULT,
  localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
  input  logic [31:0]                     i_vaddr,
  input  logic [31:0]                     i_entry_hi,
  input  logic [tlb_cfg_pkg::CATTR_W-1:0] i_k0,
  input  logic                            i_ren,
  input  logic                            i_wen,
  input  logic                            i_op_tlbp,
  output logic [tlb_cfg_pkg::PFN_W-1:0]   o_tag,
  output logic                            o_uncached,
  output logic                            o_refill,
  output logic                            o_invalid,
  output logic                            o_modify,
  output logic [31:0]                     o_probe_index,
  tlb_entry_if.reader                     entries
);
  import tlb_cfg_pkg::*;
  import mips_mmu_pkg::*;

  vaddr_u           lk_vaddr;
  logic             lk_found;
  logic [IDX_W-1:0] lk_index;
  logic             lk_valid;
  logic             lk_dirty;
  logic             lk_mapped;

  always_comb begin
    lk_vaddr = i_vaddr;
    if (i_op_tlbp) begin // Probe searches for the EntryHi page
      lk_vaddr.page.vpn2 = i_entry_hi[HI_VPN2_LSB +: VPN2_W];
      lk_vaddr.page.odd  = i_entry_hi[HI_ODD_BIT];
    end
  end

  tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_lookup (
    .i_vaddr    (lk_vaddr),
    .i_asid     (i_entry_hi[ASID_W-1:0]),
    .i_k0       (i_k0),
    .i_access   (i_ren || i_wen),
    .o_tag      (o_tag),
    .o_uncached (o_uncached),
    .o_refill   (o_refill),
    .o_invalid  (o_invalid),
    .o_found    (lk_found),
    .o_index    (lk_index),
    .o_valid    (lk_valid),
    .o_dirty    (lk_dirty),
    .o_mapped   (lk_mapped),
    .entries    (entries)
  );

  // Store to a clean page
  assign o_modify = i_wen && lk_mapped && lk_found && lk_valid && !lk_dirty;

  assign o_probe_index = lk_found ? 32'(lk_index) : PROBE_MISS;

endmodule

`default_nettype wire

//--- source/tlb_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array #(
  parameter  int TLB_ENTRIES = tlb_cfg_pkg::TLB_ENTRIES_DEFAULT,
  localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_we,
  input  logic [IDX_W-1:0] i_w_index,
  input  logic [31:0]      i_entry_hi,
  input  logic [31:0]      i_entry_lo0,
  input  logic [31:0]      i_entry_lo1,
  input  logic [IDX_W-1:0] i_r_index,
  output logic [31:0]      o_r_hi,
  output logic [31:0]      o_r_lo0,
  output logic [31:0]      o_r_lo1,
  tlb_entry_if.owner       entries
);
  import tlb_cfg_pkg::*;
  import mips_mmu_pkg::*;

  logic [VPN2_W-1:0]  vpn2_q [TLB_ENTRIES];
  logic [ASID_W-1:0]  asid_q [TLB_ENTRIES];
  logic               g_q    [TLB_ENTRIES];
  logic [PFN_W-1:0]   pfn0_q [TLB_ENTRIES];
  logic [CATTR_W-1:0] c0_q   [TLB_ENTRIES];
  logic               d0_q   [TLB_ENTRIES];
  logic               v0_q   [TLB_ENTRIES];
  logic [PFN_W-1:0]   pfn1_q [TLB_ENTRIES];
  logic [CATTR_W-1:0] c1_q   [TLB_ENTRIES];
  logic               d1_q   [TLB_ENTRIES];
  logic               v1_q   [TLB_ENTRIES];

  logic [VPN2_W-1:0]  w_vpn2;
  logic [ASID_W-1:0]  w_asid;
  logic               w_g;
  logic               r_bypass;

  function automatic logic [31:0] pack_hi(input logic [VPN2_W-1:0] vpn2,
                                          input logic [ASID_W-1:0] asid);
    logic [31:0] word;
    word = '0;
    word[HI_VPN2_LSB +: VPN2_W] = vpn2;
    word[ASID_W-1:0]            = asid;
    return word;
  endfunction

  function automatic logic [31:0] pack_lo(input logic [PFN_W-1:0] pfn,
                                          input logic [CATTR_W-1:0] c,
                                          input logic d,
                                          input logic v,
                                          input logic g);
    logic [31:0] word;
    word = '0;
    word[LO_PFN_LSB +: PFN_W] = pfn;
    word[LO_C_LSB +: CATTR_W] = c;
    word[LO_D_BIT]            = d;
    word[LO_V_BIT]            = v;
    word[LO_G_BIT]            = g;
    return word;
  endfunction

  assign w_vpn2 = i_entry_hi[HI_VPN2_LSB +: VPN2_W];
  assign w_asid = i_entry_hi[ASID_W-1:0];
  assign w_g    = i_entry_lo0[LO_G_BIT] & i_entry_lo1[LO_G_BIT]; // Global only if both pages say so

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        vpn2_q[i] <= '0;
        asid_q[i] <= '0;
        g_q[i]    <= 1'b0;
        pfn0_q[i] <= '0;
        c0_q[i]   <= '0;
        d0_q[i]   <= 1'b0;
        v0_q[i]   <= 1'b0;
        pfn1_q[i] <= '0;
        c1_q[i]   <= '0;
        d1_q[i]   <= 1'b0;
        v1_q[i]   <= 1'b0;
      end
    end else if (i_we) begin
      vpn2_q[i_w_index] <= w_vpn2;
      asid_q[i_w_index] <= w_asid;
      g_q[i_w_index]    <= w_g;
      pfn0_q[i_w_index] <= i_entry_lo0[LO_PFN_LSB +: PFN_W];
      c0_q[i_w_index]   <= i_entry_lo0[LO_C_LSB +: CATTR_W];
      d0_q[i_w_index]   <= i_entry_lo0[LO_D_BIT];
      v0_q[i_w_index]   <= i_entry_lo0[LO_V_BIT];
      pfn1_q[i_w_index] <= i_entry_lo1[LO_PFN_LSB +: PFN_W];
      c1_q[i_w_index]   <= i_entry_lo1[LO_C_LSB +: CATTR_W];
      d1_q[i_w_index]   <= i_entry_lo1[LO_D_BIT];
      v1_q[i_w_index]   <= i_entry_lo1[LO_V_BIT];
    end
  end

  assign entries.vpn2 = vpn2_q;
  assign entries.asid = asid_q;
  assign entries.g    = g_q;
  assign entries.pfn0 = pfn0_q;
  assign entries.c0   = c0_q;
  assign entries.d0   = d0_q;
  assign entries.v0   = v0_q;
  assign entries.pfn1 = pfn1_q;
  assign entries.c1   = c1_q;
  assign entries.d1   = d1_q;
  assign entries.v1   = v1_q;

  // Same-cycle write to the read index wins
  assign r_bypass = i_we && (i_r_index == i_w_index);

  assign o_r_hi = r_bypass ? pack_hi(w_vpn2, w_asid)
                           : pack_hi(vpn2_q[i_r_index], asid_q[i_r_index]);

  assign o_r_lo0 = r_bypass ? pack_lo(i_entry_lo0[LO_PFN_LSB +: PFN_W],
                                      i_entry_lo0[LO_C_LSB +: CATTR_W],
                                      i_entry_lo0[LO_D_BIT], i_entry_lo0[LO_V_BIT], w_g)
                            : pack_lo(pfn0_q[i_r_index], c0_q[i_r_index],
                                      d0_q[i_r_index], v0_q[i_r_index], g_q[i_r_index]);

  assign o_r_lo1 = r_bypass ? pack_lo(i_entry_lo1[LO_PFN_LSB +: PFN_W],
                                      i_entry_lo1[LO_C_LSB +: CATTR_W],
                                      i_entry_lo1[LO_D_BIT], i_entry_lo1[LO_V_BIT], w_g)
                            : pack_lo(pfn1_q[i_r_index], c1_q[i_r_index],
                                      d1_q[i_r_index], v1_q[i_r_index], g_q[i_r_index]);

endmodule

`default_nettype wire

//--- source/tlb_entry_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tlb_entry_if #(
  parameter int TLB_ENTRIES = tlb_cfg_pkg::TLB_ENTRIES_DEFAULT
);
  import tlb_cfg_pkg::*;

  logic [VPN2_W-1:0]  vpn2 [TLB_ENTRIES];
  logic [ASID_W-1:0]  asid [TLB_ENTRIES];
  logic               g    [TLB_ENTRIES];

  logic [PFN_W-1:0]   pfn0 [TLB_ENTRIES]; // Even page
  logic [CATTR_W-1:0] c0   [TLB_ENTRIES];
  logic               d0   [TLB_ENTRIES];
  logic               v0   [TLB_ENTRIES];

  logic [PFN_W-1:0]   pfn1 [TLB_ENTRIES]; // Odd page
  logic [CATTR_W-1:0] c1   [TLB_ENTRIES];
  logic               d1   [TLB_ENTRIES];
  logic               v1   [TLB_ENTRIES];

  modport owner (output vpn2, asid, g, pfn0, c0, d0, v0, pfn1, c1, d1, v1);
  modport reader (input vpn2, asid, g, pfn0, c0, d0, v0, pfn1, c1, d1, v1);

endinterface

`default_nettype wire

//--- source/tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup #(
  parameter  int TLB_ENTRIES = tlb_cfg_pkg::TLB_ENTRIES_DEFAULT,
  localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
  input  mips_mmu_pkg::vaddr_u            i_vaddr,
  input  logic [tlb_cfg_pkg::ASID_W-1:0]  i_asid,
  input  logic [tlb_cfg_pkg::CATTR_W-1:0] i_k0,
  input  logic                            i_access,
  output logic [tlb_cfg_pkg::PFN_W-1:0]   o_tag,
  output logic                            o_uncached,
  output logic                            o_refill,
  output logic                            o_invalid,
  output logic                            o_found,
  output logic [IDX_W-1:0]                o_index,
  output logic                            o_valid,
  output logic                            o_dirty,
  output logic                            o_mapped,
  tlb_entry_if.reader                     entries
);
  import tlb_cfg_pkg::*;
  import mips_mmu_pkg::*;

  logic [TLB_ENTRIES-1:0] match;
  logic [PFN_W-1:0]       pfn0;
  logic [PFN_W-1:0]       pfn1;
  logic [CATTR_W-1:0]     c0;
  logic [CATTR_W-1:0]     c1;
  logic                   d0;
  logic                   d1;
  logic                   v0;
  logic                   v1;
  logic [PFN_W-1:0]       pfn;
  logic [CATTR_W-1:0]     c;
  logic [2:0]             seg;
  logic                   kseg0;
  logic                   kseg1;

  for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_match
    assign match[i] = (i_vaddr.page.vpn2 == entries.vpn2[i]) &&
                      (entries.g[i] || (i_asid == entries.asid[i]));
  end

  // Multiple hits OR together
  always_comb begin
    o_index = '0;
    pfn0    = '0;
    pfn1    = '0;
    c0      = '0;
    c1      = '0;
    d0      = 1'b0;
    d1      = 1'b0;
    v0      = 1'b0;
    v1      = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (match[i]) begin
        o_index = o_index | IDX_W'(i);
        pfn0    = pfn0 | entries.pfn0[i];
        pfn1    = pfn1 | entries.pfn1[i];
        c0      = c0 | entries.c0[i];
        c1      = c1 | entries.c1[i];
        d0      = d0 | entries.d0[i];
        d1      = d1 | entries.d1[i];
        v0      = v0 | entries.v0[i];
        v1      = v1 | entries.v1[i];
      end
    end
  end

  assign o_found = |match;

  // Bit 12 picks the page of the pair
  assign pfn     = i_vaddr.page.odd ? pfn1 : pfn0;
  assign c       = i_vaddr.page.odd ? c1 : c0;
  assign o_dirty = i_vaddr.page.odd ? d1 : d0;
  assign o_valid = i_vaddr.page.odd ? v1 : v0;

  assign seg      = i_vaddr.seg.seg;
  assign kseg0    = (seg == SEG_KSEG0);
  assign kseg1    = (seg == SEG_KSEG1);
  assign o_mapped = !seg[2] || (seg == SEG_KSEG2) || (seg == SEG_KSEG3); // kuseg is 0xx

  // Unmapped tag is the physical page straight from the address
  assign o_tag = o_mapped ? pfn : PFN_W'(i_vaddr.seg.rest[28:12]);

  assign o_uncached = kseg1 ? 1'b1 :
                      kseg0 ? (i_k0 != CACHE_CACHEABLE) :
                              (c != CACHE_CACHEABLE);

  assign o_refill  = i_access && o_mapped && !o_found;
  assign o_invalid = i_access && o_mapped && o_found && !o_valid;

endmodule

`default_nettype wire

//--- source/tlb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_top #(
  parameter  int TLB_ENTRIES = tlb_cfg_pkg::TLB_ENTRIES_DEFAULT,
  localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [tlb_cfg_pkg::CATTR_W-1:0] i_k0,

  // Instruction lookup
  input  logic                            i_inst_en,
  input  logic [31:0]                     i_inst_vaddr,
  output logic [tlb_cfg_pkg::PFN_W-1:0]   o_inst_tag,
  output logic                            o_inst_uncached,
  output logic                            o_inst_refill,
  output logic                            o_inst_invalid,

  // Data lookup and probe
  input  logic                            i_data_ren,
  input  logic                            i_data_wen,
  input  logic [31:0]                     i_data_vaddr,
  input  logic                            i_op_tlbp,
  output logic [tlb_cfg_pkg::PFN_W-1:0]   o_data_tag,
  output logic                            o_data_uncached,
  output logic                            o_data_refill,
  output logic                            o_data_invalid,
  output logic                            o_data_modify,
  output logic [31:0]                     o_probe_index,

  // Entry write and read-back
  input  logic                            i_we,
  input  logic [IDX_W-1:0]                i_w_index,
  input  logic [31:0]                     i_entry_hi,
  input  logic [31:0]                     i_entry_lo0,
  input  logic [31:0]                     i_entry_lo1,
  input  logic [IDX_W-1:0]                i_r_index,
  output logic [31:0]                     o_r_hi,
  output logic [31:0]                     o_r_lo0,
  output logic [31:0]                     o_r_lo1
);
  import tlb_cfg_pkg::*;

  tlb_entry_if #(.TLB_ENTRIES(TLB_ENTRIES)) entries_bus ();

  tlb_entry_array #(.TLB_ENTRIES(TLB_ENTRIES)) u_array (
    .clk         (clk),
    .rst         (rst),
    .i_we        (i_we),
    .i_w_index   (i_w_index),
    .i_entry_hi  (i_entry_hi),
    .i_entry_lo0 (i_entry_lo0),
    .i_entry_lo1 (i_entry_lo1),
    .i_r_index   (i_r_index),
    .o_r_hi      (o_r_hi),
    .o_r_lo0     (o_r_lo0),
    .o_r_lo1     (o_r_lo1),
    .entries     (entries_bus.owner)
  );

  // Fetch needs no hit details beyond the exceptions
  tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_inst_lookup (
    .i_vaddr    (i_inst_vaddr),
    .i_asid     (i_entry_hi[ASID_W-1:0]), // Current ASID
    .i_k0       (i_k0),
    .i_access   (i_inst_en),
    .o_tag      (o_inst_tag),
    .o_uncached (o_inst_uncached),
    .o_refill   (o_inst_refill),
    .o_invalid  (o_inst_invalid),
    .o_found    (),
    .o_index    (),
    .o_valid    (),
    .o_dirty    (),
    .o_mapped   (),
    .entries    (entries_bus.reader)
  );

  tlb_data_port #(.TLB_ENTRIES(TLB_ENTRIES)) u_data_port (
    .i_vaddr       (i_data_vaddr),
    .i_entry_hi    (i_entry_hi),
    .i_k0          (i_k0),
    .i_ren         (i_data_ren),
    .i_wen         (i_data_wen),
    .i_op_tlbp     (i_op_tlbp),
    .o_tag         (o_data_tag),
    .o_uncached    (o_data_uncached),
    .o_refill      (o_data_refill),
    .o_invalid     (o_data_invalid),
    .o_modify      (o_data_modify),
    .o_probe_index (o_probe_index),
    .entries       (entries_bus.reader)
  );

endmodule

`default_nettype wire

//--- tests/tb_tlb_tasks.svh
`ifndef TB_TLB_TASKS_SVH
`define TB_TLB_TASKS_SVH

task automatic check_tag(input string name, input logic [PFN_W-1:0] exp_val,
                         input logic [PFN_W-1:0] act_val);
  if (act_val !== exp_val) begin
    $display("Mismatch %s: expected %h, got %h", name, exp_val, act_val);
    $display("STATUS: FAIL");
    $fatal(1, "tag compare failed");
  end
endtask

task automatic check_word(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
  if (act_val !== exp_val) begin
    $display("Mismatch %s: expected %h, got %h", name, exp_val, act_val);
    $display("STATUS: FAIL");
    $fatal(1, "word compare failed");
  end
endtask

task automatic check_flag(input string name, input logic exp_val, input logic act_val);
  if (act_val !== exp_val) begin
    $display("Mismatch %s: expected %h, got %h", name, exp_val, act_val);
    $display("STATUS: FAIL");
    $fatal(1, "flag compare failed");
  end
endtask

task automatic wait_reset_release();
  int cycles;
  cycles = 0;
  while (rst) begin
    @(posedge clk);
    cycles++;
    if (cycles > RESET_TIMEOUT) begin
      $display("Reset was not released in time");
      $display("STATUS: FAIL");
      $fatal(1, "reset wait timed out");
    end
  end
endtask

// Bits 12..8 of EntryHi are not stored
function automatic logic [31:0] hi_readback(input logic [31:0] hi);
  return hi & 32'hFFFF_E0FF;
endfunction

function automatic logic [31:0] lo_readback(input logic [31:0] lo, input logic g);
  return {6'b0, lo[25:1], g};
endfunction

// Same address on both ports and sampled at the falling edge
task automatic lookup(input logic [31:0] va, input logic [7:0] asid,
                      input logic en, input logic wen);
  @(posedge clk);
  inst_vaddr <= va;
  data_vaddr <= va;
  inst_en    <= en;
  data_ren   <= en & !wen;
  data_wen   <= wen;
  entry_hi   <= {24'h0, asid};
  @(negedge clk);
endtask

task automatic read_expect(input int idx, input logic [31:0] hi, input logic [31:0] lo0,
                           input logic [31:0] lo1);
  @(posedge clk);
  r_index <= IDX_W'(idx);
  @(negedge clk);
  check_word("o_r_hi", hi, r_hi);
  check_word("o_r_lo0", lo0, r_lo0);
  check_word("o_r_lo1", lo1, r_lo1);
endtask

// Also reads the same index in the write cycle
task automatic write_entry(input int idx, input logic [31:0] hi, input logic [31:0] lo0,
                           input logic [31:0] lo1);
  logic g;
  g = lo0[0] & lo1[0];
  @(posedge clk);
  we        <= 1'b1;
  w_index   <= IDX_W'(idx);
  r_index   <= IDX_W'(idx);
  entry_hi  <= hi;
  entry_lo0 <= lo0;
  entry_lo1 <= lo1;
  @(negedge clk);
  check_word("o_r_hi bypass", hi_readback(hi), r_hi);
  check_word("o_r_lo0 bypass", lo_readback(lo0, g), r_lo0);
  check_word("o_r_lo1 bypass", lo_readback(lo1, g), r_lo1);
  @(posedge clk);
  we <= 1'b0;
  ent_hi[idx]  = hi;
  ent_lo0[idx] = lo0;
  ent_lo1[idx] = lo1;
endtask

task automatic after_reset();
  for (int i = 0; i < ENTRIES; i++)
    read_expect(i, 32'h0, 32'h0, 32'h0);
  lookup(32'h0040_3000, 8'h00, 1'b1, 1'b0);
  check_flag("o_inst_refill", 1'b1, inst_refill);
  check_flag("o_data_refill", 1'b1, data_refill);
  lookup(32'h0040_3000, 8'h00, 1'b0, 1'b0); // Enables low
  check_flag("o_inst_refill", 1'b0, inst_refill);
  check_flag("o_data_refill", 1'b0, data_refill);
endtask

task automatic unmapped_segments();
  logic [31:0]        rnd;
  logic [31:0]        va;
  logic [CATTR_W-1:0] kval;
  logic               exp_unc;
  for (int n = 0; n < 8; n++) begin
    rnd  = lcg_next();
    va   = {(n % 2 == 0) ? 3'b100 : 3'b101, rnd[28:0]};
    kval = n[1] ? 3'd2 : 3'd3;
    @(posedge clk);
    k0 <= kval;
    lookup(va, rnd[7:0], 1'b1, 1'b1);
    exp_unc = va[29] ? 1'b1 : (kval != 3'd3); // kseg1 never cached
    check_tag("o_inst_tag", {3'b000, va[28:12]}, inst_tag);
    check_tag("o_data_tag", {3'b000, va[28:12]}, data_tag);
    check_flag("o_inst_uncached", exp_unc, inst_uncached);
    check_flag("o_data_uncached", exp_unc, data_uncached);
    check_flag("o_inst_refill", 1'b0, inst_refill);
    check_flag("o_data_refill", 1'b0, data_refill);
    check_flag("o_inst_invalid", 1'b0, inst_invalid);
    check_flag("o_data_invalid", 1'b0, data_invalid);
    check_flag("o_data_modify", 1'b0, data_modify);
  end
endtask

task automatic write_and_read_back();
  logic [VPN2_W-1:0] vpn2;
  logic [31:0]       hi;
  logic [31:0]       lo0;
  logic [31:0]       lo1;
  logic              g;
  for (int i = 0; i < ENTRIES; i++) begin
    vpn2 = VPN2_W'(lcg_next() << IDX_W) | VPN2_W'(i); // Low bits keep VPN2 distinct
    vpn2[VPN2_W-2] = vpn2[VPN2_W-2] | vpn2[VPN2_W-1];  // Stay out of kseg0/kseg1
    hi = lcg_next();
    hi[31:13] = vpn2;
    lo0 = lcg_next();
    lo1 = lcg_next();
    if (i % 4 == 0) begin
      lo0[0] = 1'b1;
      lo1[0] = 1'b1;
    end
    write_entry(i, hi, lo0, lo1);
  end
  for (int i = 0; i < ENTRIES; i++) begin
    g = ent_lo0[i][0] & ent_lo1[i][0];
    read_expect(i, hi_readback(ent_hi[i]), lo_readback(ent_lo0[i], g),
                lo_readback(ent_lo1[i], g));
  end
endtask

task automatic mapped_translation();
  logic [31:0] va;
  logic [31:0] lo;
  logic        g;
  for (int i = 0; i < ENTRIES; i++) begin
    for (int p = 0; p < 2; p++) begin
      va = {ent_hi[i][31:13], p[0], 12'h0a4};
      lo = p[0] ? ent_lo1[i] : ent_lo0[i];
      g  = ent_lo0[i][0] & ent_lo1[i][0];
      lookup(va, ent_hi[i][7:0], 1'b1, 1'b0);
      check_tag("o_inst_tag", lo[25:6], inst_tag);
      check_tag("o_data_tag", lo[25:6], data_tag);
      check_flag("o_inst_uncached", lo[5:3] != 3'd3, inst_uncached);
      check_flag("o_data_uncached", lo[5:3] != 3'd3, data_uncached);
      check_flag("o_inst_refill", 1'b0, inst_refill);
      check_flag("o_data_refill", 1'b0, data_refill);
      check_flag("o_inst_invalid", !lo[1], inst_invalid);
      check_flag("o_data_invalid", !lo[1], data_invalid);
      // Foreign ASID hits only global entries
      lookup(va, ent_hi[i][7:0] ^ 8'h5a, 1'b1, 1'b0);
      check_flag("o_inst_refill", !g, inst_refill);
      check_flag("o_data_refill", !g, data_refill);
      if (g)
        check_tag("o_data_tag", lo[25:6], data_tag);
    end
  end
endtask

task automatic page_exceptions();
  logic [31:0] hi;
  logic [31:0] lo0;
  logic [31:0] lo1;
  logic [31:0] rnd0;
  logic [31:0] rnd1;
  hi   = ent_hi[0];
  rnd0 = lcg_next();
  rnd1 = lcg_next();
  lo0  = {6'b0, rnd0[19:0], 3'd3, 1'b1, 1'b0, 1'b0}; // Dirty, not valid
  lo1  = {6'b0, rnd1[19:0], 3'd3, 1'b0, 1'b1, 1'b0}; // Valid, clean
  write_entry(0, hi, lo0, lo1);
  lookup({hi[31:13], 1'b0, 12'h010}, hi[7:0], 1'b1, 1'b0);
  check_flag("o_inst_invalid", 1'b1, inst_invalid);
  check_flag("o_data_invalid", 1'b1, data_invalid);
  check_flag("o_inst_refill", 1'b0, inst_refill);
  check_flag("o_data_refill", 1'b0, data_refill);
  lookup({hi[31:13], 1'b1, 12'h010}, hi[7:0], 1'b1, 1'b1);
  check_flag("o_data_modify", 1'b1, data_modify);
  check_flag("o_data_invalid", 1'b0, data_invalid);
  check_flag("o_data_refill", 1'b0, data_refill);
  lookup({hi[31:13], 1'b1, 12'h010}, hi[7:0], 1'b1, 1'b0);
  check_flag("o_data_modify", 1'b0, data_modify);
endtask

task automatic probe_lookup();
  logic [31:0] hi;
  for (int i = 0; i < ENTRIES; i++) begin
    @(posedge clk);
    op_tlbp  <= 1'b1;
    entry_hi <= ent_hi[i];
    inst_en  <= 1'b0;
    data_ren <= 1'b0;
    data_wen <= 1'b0;
    @(negedge clk);
    check_word("o_probe_index", 32'(i), probe_index);
  end
  hi = ent_hi[0];
  hi[13 + IDX_W] = ~hi[13 + IDX_W]; // VPN2 no entry holds
  @(posedge clk);
  entry_hi <= hi;
  @(negedge clk);
  check_word("o_probe_index", 32'h8000_0000, probe_index);
  @(posedge clk);
  op_tlbp <= 1'b0;
endtask

`endif

//--- tests/tb_tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tlb;
  import tlb_cfg_pkg::*;

  localparam int ENTRIES       = TLB_ENTRIES_DEFAULT;
  localparam int IDX_W         = $clog2(ENTRIES);
  localparam int RESET_TIMEOUT = 20; // Cycles

  logic               clk;
  logic               rst;
  logic [CATTR_W-1:0] k0;
  logic               inst_en;
  logic [31:0]        inst_vaddr;
  logic               data_ren;
  logic               data_wen;
  logic [31:0]        data_vaddr;
  logic               op_tlbp;
  logic               we;
  logic [IDX_W-1:0]   w_index;
  logic [31:0]        entry_hi;
  logic [31:0]        entry_lo0;
  logic [31:0]        entry_lo1;
  logic [IDX_W-1:0]   r_index;

  logic [PFN_W-1:0]   inst_tag;
  logic               inst_uncached;
  logic               inst_refill;
  logic               inst_invalid;
  logic [PFN_W-1:0]   data_tag;
  logic               data_uncached;
  logic               data_refill;
  logic               data_invalid;
  logic               data_modify;
  logic [31:0]        probe_index;
  logic [31:0]        r_hi;
  logic [31:0]        r_lo0;
  logic [31:0]        r_lo1;

  // Raw words last written to each index
  logic [31:0] ent_hi  [ENTRIES];
  logic [31:0] ent_lo0 [ENTRIES];
  logic [31:0] ent_lo1 [ENTRIES];

  logic [31:0] lcg_state;

  tlb_top #(.TLB_ENTRIES(ENTRIES)) i_dut (
    .clk             (clk),
    .rst             (rst),
    .i_k0            (k0),
    .i_inst_en       (inst_en),
    .i_inst_vaddr    (inst_vaddr),
    .o_inst_tag      (inst_tag),
    .o_inst_uncached (inst_uncached),
    .o_inst_refill   (inst_refill),
    .o_inst_invalid  (inst_invalid),
    .i_data_ren      (data_ren),
    .i_data_wen      (data_wen),
    .i_data_vaddr    (data_vaddr),
    .i_op_tlbp       (op_tlbp),
    .o_data_tag      (data_tag),
    .o_data_uncached (data_uncached),
    .o_data_refill   (data_refill),
    .o_data_invalid  (data_invalid),
    .o_data_modify   (data_modify),
    .o_probe_index   (probe_index),
    .i_we            (we),
    .i_w_index       (w_index),
    .i_entry_hi      (entry_hi),
    .i_entry_lo0     (entry_lo0),
    .i_entry_lo1     (entry_lo1),
    .i_r_index       (r_index),
    .o_r_hi          (r_hi),
    .o_r_lo0         (r_lo0),
    .o_r_lo1         (r_lo1)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "tb_tlb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    lcg_state  = 32'h5952;
    rst        = 1'b1;
    k0         = 3'd3;
    inst_en    = 1'b0;
    inst_vaddr = '0;
    data_ren   = 1'b0;
    data_wen   = 1'b0;
    data_vaddr = '0;
    op_tlbp    = 1'b0;
    we         = 1'b0;
    w_index    = '0;
    entry_hi   = '0;
    entry_lo0  = '0;
    entry_lo1  = '0;
    r_index    = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    wait_reset_release();

    after_reset();
    unmapped_segments(); // TLB still empty here
    write_and_read_back();
    mapped_translation();
    page_exceptions();
    probe_lookup();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tests
source/tlb_cfg_pkg.sv
source/mips_mmu_pkg.sv
source/tlb_entry_if.sv
source/tlb_entry_array.sv
source/tlb_lookup.sv
source/tlb_data_port.sv
source/tlb_top.sv
tests/tb_tlb.sv
